// File: build.f
logic/aznable_pkg.sv
logic/periph_bus_if.sv
logic/video_timing.sv
logic/system_bus.sv
logic/input_ports.sv
logic/ms_timer.sv
logic/system_memory.sv
logic/system_top.sv
verif/system_tb.sv

// File: logic/aznable_pkg.sv
package aznable_pkg;

	// Bus and data widths
	typedef logic [7:0] byte_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] page_t;
	typedef logic [16:0] dn_addr_t;
	typedef logic [8:0] pixel_cnt_t;
	typedef logic [15:0] timer_t;

	// Visible area and full raster, in pixels and lines
	localparam pixel_cnt_t H_VISIBLE = 9'd320;
	localparam pixel_cnt_t V_VISIBLE = 9'd240;
	localparam pixel_cnt_t H_TOTAL = 9'd396;
	localparam pixel_cnt_t V_TOTAL = 9'd256;

	// Sync windows, start inclusive and end exclusive
	localparam pixel_cnt_t H_SYNC_START = 9'd336;
	localparam pixel_cnt_t H_SYNC_END = 9'd368;
	localparam pixel_cnt_t V_SYNC_START = 9'd244;
	localparam pixel_cnt_t V_SYNC_END = 9'd248;

	// Memory mapped input and timer pages
	localparam page_t PAGE_STATUS = 8'h80;
	localparam page_t PAGE_JOYSTICK = 8'h81;
	localparam page_t PAGE_PADDLE = 8'h84;
	localparam page_t PAGE_TIMESTAMP = 8'h88;
	localparam page_t PAGE_TIMER = 8'h89;

	// Pause trigger covers 0x8A30 to 0x8A3F
	localparam logic [11:0] PAUSE_NIBBLES = 12'h8A3;

	// Memory sizes as address widths
	localparam int PGROM_ADDR_W = 15;
	localparam int WKRAM_ADDR_W = 14;

	// Download slot of the program ROM
	localparam byte_t DN_INDEX_PGROM = 8'd0;

	// Clocks per millisecond at 24 MHz
	localparam int CLK_TICKS_PER_MS = 24000;

	// Source codes seen by the input peripheral in addr[7:6]
	localparam logic [1:0] SRC_JOYSTICK = 2'd0;
	localparam logic [1:0] SRC_PADDLE = 2'd1;
	localparam logic [1:0] SRC_TIMESTAMP = 2'd2;

endpackage

// File: logic/input_ports.sv
`timescale 1ns/1ps

module input_ports
	import aznable_pkg::*;
#(
	parameter int JOY_DEVICES = 6,
	parameter int PADDLE_DEVICES = 6
)
(
	// 32 buttons per joystick
	input logic [JOY_DEVICES*32-1:0] joystick,
	// One byte per paddle
	input logic [PADDLE_DEVICES*8-1:0] paddle,
	// Seconds count with a change toggle in bit 32
	input logic [32:0] timestamp,
	periph_bus_if.periph input_bus
);

	localparam int JOY_BYTES = JOY_DEVICES * 4;
	localparam int PADDLE_BYTES = PADDLE_DEVICES;

	// Sources padded to the full offset range so that spare bytes read 0
	logic [32*8-1:0] joy_ext;
	logic [8*8-1:0] paddle_ext;
	logic [8*8-1:0] timestamp_ext;
	byte_t joy_byte;
	byte_t paddle_byte;
	byte_t timestamp_byte;
	byte_t src_byte;

	assign joy_ext = (32*8)'(joystick);
	assign paddle_ext = (8*8)'(paddle);
	assign timestamp_ext = (8*8)'(timestamp);

	assign joy_byte = joy_ext[{input_bus.addr[4:0], 3'd0} +: 8];
	assign paddle_byte = paddle_ext[{input_bus.addr[2:0], 3'd0} +: 8];
	assign timestamp_byte = timestamp_ext[{input_bus.addr[2:0], 3'd0} +: 8];

	always_comb
	begin
		case (input_bus.addr[7:6])
			SRC_JOYSTICK: src_byte = joy_byte;
			SRC_PADDLE: src_byte = paddle_byte;
			SRC_TIMESTAMP: src_byte = timestamp_byte;
			default: src_byte = 8'h00;
		endcase
	end

	assign input_bus.rdata = input_bus.sel ? src_byte : 8'h00;

	// Offsets only reach 32 joystick and 8 paddle bytes
	initial
	begin
		assert (JOY_BYTES <= 32 && PADDLE_BYTES <= 8)
		else $error("input_ports: too many devices for the page offsets");
	end

endmodule

// File: logic/ms_timer.sv
`timescale 1ns/1ps

module ms_timer
	import aznable_pkg::*;
#(
	parameter int TICKS_PER_MS = 24000
)
(
	input logic clk_24,
	input logic reset,
	periph_bus_if.periph timer_bus
);

	localparam int PRESCALE_W = $clog2(TICKS_PER_MS);

	logic [PRESCALE_W-1:0] prescale;
	timer_t count;
	logic clear;
	logic ms_tick;

	// Any write to the page restarts the count
	assign clear = timer_bus.sel && timer_bus.wr;
	assign ms_tick = (prescale == PRESCALE_W'(TICKS_PER_MS - 1));

	always_ff @(posedge clk_24)
	begin
		if (reset || clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (ms_tick)
		begin
			prescale <= '0;
			count <= count + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	// addr bit 0 picks the high byte
	assign timer_bus.rdata = !timer_bus.sel ? 8'h00 :
		timer_bus.addr[0] ? count[15:8] : count[7:0];

	a_clear_to_zero: assert property (@(posedge clk_24) disable iff (reset)
		clear |=> (count == '0));

endmodule

// File: logic/periph_bus_if.sv
`timescale 1ns/1ps

interface periph_bus_if;

	// Slot select, a level decoded from the CPU address
	logic sel;
	aznable_pkg::byte_t addr;
	aznable_pkg::byte_t wdata;
	// Raw CPU write strobe
	logic wr;
	aznable_pkg::byte_t rdata;

	modport decoder (
		output sel,
		output addr,
		output wdata,
		output wr,
		input rdata
	);

	modport periph (
		input sel,
		input addr,
		input wdata,
		input wr,
		output rdata
	);

endinterface

// File: logic/system_bus.sv
`timescale 1ns/1ps

module system_bus
	import aznable_pkg::*;
(
	input logic clk_24,
	input logic reset,
	input logic pause,
	input cpu_addr_t cpu_addr,
	input byte_t cpu_dout,
	input logic cpu_wr,
	input logic vga_hs,
	input logic vga_vs,
	input logic vga_hb,
	input logic vga_vb,
	output byte_t cpu_din,
	output logic cpu_wait,
	periph_bus_if.decoder rom_bus,
	periph_bus_if.decoder ram_bus,
	periph_bus_if.decoder input_bus,
	periph_bus_if.decoder timer_bus
);

	page_t page;
	logic rom_sel;
	logic ram_sel;
	logic status_sel;
	logic joystick_sel;
	logic paddle_sel;
	logic timestamp_sel;
	logic input_sel;
	logic timer_sel;
	logic pause_sel;
	logic [1:0] input_src;
	byte_t status_byte;

	// Set only by a CPU write, cleared by the pause input
	logic pause_trigger = 1'b0;

	assign page = cpu_addr[15:8];

	// Address decode
	assign rom_sel = (cpu_addr[15] == 1'b0);
	assign ram_sel = (cpu_addr[15:14] == 2'b11);
	assign status_sel = (page == PAGE_STATUS);
	assign joystick_sel = (page == PAGE_JOYSTICK);
	assign paddle_sel = (page == PAGE_PADDLE);
	assign timestamp_sel = (page == PAGE_TIMESTAMP);
	assign input_sel = joystick_sel || paddle_sel || timestamp_sel;
	assign timer_sel = (page == PAGE_TIMER);
	assign pause_sel = (cpu_addr[15:4] == PAUSE_NIBBLES);

	// The input peripheral sees the source in the top two addr bits
	assign input_src = paddle_sel ? SRC_PADDLE :
		timestamp_sel ? SRC_TIMESTAMP : SRC_JOYSTICK;

	// Slot buses
	assign rom_bus.sel = rom_sel;
	assign rom_bus.addr = cpu_addr[7:0];
	assign rom_bus.wdata = cpu_dout;
	assign rom_bus.wr = cpu_wr;

	assign ram_bus.sel = ram_sel;
	assign ram_bus.addr = cpu_addr[7:0];
	assign ram_bus.wdata = cpu_dout;
	assign ram_bus.wr = cpu_wr;

	assign input_bus.sel = input_sel;
	assign input_bus.addr = {input_src, cpu_addr[5:0]};
	assign input_bus.wdata = cpu_dout;
	assign input_bus.wr = cpu_wr;

	assign timer_bus.sel = timer_sel;
	assign timer_bus.addr = cpu_addr[7:0];
	assign timer_bus.wdata = cpu_dout;
	assign timer_bus.wr = cpu_wr;

	// hs vs hb vb, then 1000
	assign status_byte = {vga_hs, vga_vs, vga_hb, vga_vb, 4'b1000};

	// Read data mux
	assign cpu_din = rom_sel ? rom_bus.rdata :
		ram_sel ? ram_bus.rdata :
		input_sel ? input_bus.rdata :
		timer_sel ? timer_bus.rdata :
		status_sel ? status_byte :
		8'h00;

	// System pause latch
	always_ff @(posedge clk_24)
	begin
		if (pause)
			pause_trigger <= 1'b0;
		else if (pause_sel && cpu_wr)
			pause_trigger <= 1'b1;
	end

	assign cpu_wait = pause || pause_trigger;

	a_one_slot: assert property (@(posedge clk_24) disable iff (reset)
		$onehot0({rom_sel, ram_sel, input_sel, timer_sel, status_sel, pause_sel}));

endmodule

// File: logic/system_memory.sv
`timescale 1ns/1ps

module system_memory
	import aznable_pkg::*;
(
	input logic clk_24,
	input cpu_addr_t cpu_addr,
	input dn_addr_t dn_addr,
	input byte_t dn_data,
	input logic dn_wr,
	input byte_t dn_index,
	periph_bus_if.periph rom_bus,
	periph_bus_if.periph ram_bus
);

	localparam int PGROM_DEPTH = 1 << PGROM_ADDR_W;
	localparam int WKRAM_DEPTH = 1 << WKRAM_ADDR_W;

	byte_t pgrom [0:PGROM_DEPTH-1];
	byte_t wkram [0:WKRAM_DEPTH-1];

	logic [PGROM_ADDR_W-1:0] pgrom_cpu_addr;
	logic [PGROM_ADDR_W-1:0] pgrom_dn_addr;
	logic [WKRAM_ADDR_W-1:0] wkram_addr;
	logic pgrom_wr;
	logic wkram_wr;
	byte_t pgrom_q;
	byte_t wkram_q;

	// Low byte arrives on the slot bus, the rest from the CPU address
	assign pgrom_cpu_addr = {cpu_addr[PGROM_ADDR_W-1:8], rom_bus.addr};
	assign wkram_addr = {cpu_addr[WKRAM_ADDR_W-1:8], ram_bus.addr};
	assign pgrom_dn_addr = dn_addr[PGROM_ADDR_W-1:0];

	// Only download slot 0 loads the program ROM
	assign pgrom_wr = dn_wr && (dn_index == DN_INDEX_PGROM);
	assign wkram_wr = ram_bus.sel && ram_bus.wr;

	// Program ROM download port
	always_ff @(posedge clk_24)
	begin
		if (pgrom_wr)
			pgrom[pgrom_dn_addr] <= dn_data;
	end

	// Program ROM CPU port, read only
	always_ff @(posedge clk_24)
	begin
		pgrom_q <= pgrom[pgrom_cpu_addr];
	end

	// Working RAM, read before write
	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
			wkram[wkram_addr] <= ram_bus.wdata;
		wkram_q <= wkram[wkram_addr];
	end

	assign rom_bus.rdata = pgrom_q;
	assign ram_bus.rdata = wkram_q;

endmodule

// File: logic/system_top.sv
`timescale 1ns/1ps

module system_top
	import aznable_pkg::*;
#(
	parameter int TICKS_PER_MS = CLK_TICKS_PER_MS,
	parameter int JOY_DEVICES = 6,
	parameter int PADDLE_DEVICES = 6
)
(
	input logic clk_24,
	input logic ce_6,
	input logic reset,
	input logic pause,
	input cpu_addr_t cpu_addr,
	input byte_t cpu_dout,
	input logic cpu_wr,
	input dn_addr_t dn_addr,
	input logic dn_wr,
	input byte_t dn_data,
	input byte_t dn_index,
	input logic [JOY_DEVICES*32-1:0] joystick,
	input logic [PADDLE_DEVICES*8-1:0] paddle,
	input logic [32:0] timestamp,
	output byte_t cpu_din,
	output logic cpu_wait,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_hb,
	output logic vga_vb
);

	periph_bus_if rom_bus();
	periph_bus_if ram_bus();
	periph_bus_if input_bus();
	periph_bus_if timer_bus();

	// Counters are not needed outside the timing block
	video_timing video_timing_i (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.hcnt(),
		.vcnt(),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb)
	);

	system_bus system_bus_i (
		.clk_24(clk_24),
		.reset(reset),
		.pause(pause),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_wr(cpu_wr),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb),
		.cpu_din(cpu_din),
		.cpu_wait(cpu_wait),
		.rom_bus(rom_bus.decoder),
		.ram_bus(ram_bus.decoder),
		.input_bus(input_bus.decoder),
		.timer_bus(timer_bus.decoder)
	);

	input_ports #(
		.JOY_DEVICES(JOY_DEVICES),
		.PADDLE_DEVICES(PADDLE_DEVICES)
	) input_ports_i (
		.joystick(joystick),
		.paddle(paddle),
		.timestamp(timestamp),
		.input_bus(input_bus.periph)
	);

	ms_timer #(
		.TICKS_PER_MS(TICKS_PER_MS)
	) ms_timer_i (
		.clk_24(clk_24),
		.reset(reset),
		.timer_bus(timer_bus.periph)
	);

	system_memory system_memory_i (
		.clk_24(clk_24),
		.cpu_addr(cpu_addr),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_wr(dn_wr),
		.dn_index(dn_index),
		.rom_bus(rom_bus.periph),
		.ram_bus(ram_bus.periph)
	);

endmodule

// File: logic/video_timing.sv
`timescale 1ns/1ps

module video_timing
	import aznable_pkg::*;
(
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	output pixel_cnt_t hcnt,
	output pixel_cnt_t vcnt,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_hb,
	output logic vga_vb
);

	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (hcnt == H_TOTAL - 1'b1);
	assign v_wrap = (vcnt == V_TOTAL - 1'b1);

	// Pixel and line counters, stepping on the pixel enable
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (ce_6)
		begin
			if (h_wrap)
			begin
				hcnt <= '0;
				vcnt <= v_wrap ? '0 : vcnt + 1'b1;
			end
			else
			begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// Blank and sync, registered from the counts
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			vga_hb <= 1'b0;
			vga_vb <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end
		else
		begin
			vga_hb <= (hcnt >= H_VISIBLE);
			vga_vb <= (vcnt >= V_VISIBLE);
			vga_hs <= (hcnt >= H_SYNC_START) && (hcnt < H_SYNC_END);
			vga_vs <= (vcnt >= V_SYNC_START) && (vcnt < V_SYNC_END);
		end
	end

	a_hcnt_in_range: assert property (@(posedge clk_24) disable iff (reset)
		hcnt < H_TOTAL);

endmodule

// File: verif/system_tb.sv
`timescale 1ns/1ps

module system_tb
	import aznable_pkg::*;
();

	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * 4;
	localparam int TIMER_LIMIT = 2 * CLK_TICKS_PER_MS;

	logic clk_24;
	logic ce_6;
	logic reset;
	logic pause;
	cpu_addr_t cpu_addr;
	byte_t cpu_dout;
	logic cpu_wr;
	dn_addr_t dn_addr;
	logic dn_wr;
	byte_t dn_data;
	byte_t dn_index;
	logic [191:0] joystick;
	logic [47:0] paddle;
	logic [32:0] timestamp;
	byte_t cpu_din;
	logic cpu_wait;
	logic vga_hs;
	logic vga_vs;
	logic vga_hb;
	logic vga_vb;

	int value_errors = 0;
	int timeout_errors = 0;
	logic [31:0] lcg_state = 32'd61;

	// Video pulse tracking, indexed hs, vs, hb, vb
	int pulse_run [4];
	int pulse_count [4];
	string pulse_names [4] = '{"vga_hs", "vga_vs", "vga_hb", "vga_vb"};

	system_top system_top_i (
		.clk_24(clk_24), .ce_6(ce_6), .reset(reset), .pause(pause),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_wr(cpu_wr),
		.dn_addr(dn_addr), .dn_wr(dn_wr), .dn_data(dn_data), .dn_index(dn_index),
		.joystick(joystick), .paddle(paddle), .timestamp(timestamp),
		.cpu_din(cpu_din), .cpu_wait(cpu_wait),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_hb(vga_hb), .vga_vb(vga_vb)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #4 clk_24 = ~clk_24;
	end

	// Pixel enable on every fourth clock
	initial
	begin
		logic [1:0] phase;
		phase = 2'd0;
		ce_6 = 1'b0;
		forever
		begin
			@(negedge clk_24);
			phase = phase + 1'b1;
			ce_6 = (phase == 2'd3);
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic byte_t random_byte();
		logic [31:0] r;
		r = next_random();
		return r[23:16];
	endfunction

	// Status page reads hs vs hb vb, then 1000
	function automatic byte_t status_rule(input logic hs, input logic vs,
		input logic hb, input logic vb);
		return {hs, vs, hb, vb, 4'b1000};
	endfunction

	// Expected high time of each video output, four clocks per pixel
	function automatic int pulse_clocks(input int k);
		case (k)
			0: return (H_SYNC_END - H_SYNC_START) * 4;
			1: return (V_SYNC_END - V_SYNC_START) * H_TOTAL * 4;
			2: return (H_TOTAL - H_VISIBLE) * 4;
			default: return (V_TOTAL - V_VISIBLE) * H_TOTAL * 4;
		endcase
	endfunction

	// Byte of an input page, zero past the end of its source
	function automatic byte_t expected_input(input page_t page, input int offset);
		if (page == PAGE_JOYSTICK && offset < 24)
			return joystick[offset*8 +: 8];
		if (page == PAGE_PADDLE && offset < 6)
			return paddle[offset*8 +: 8];
		if (page == PAGE_TIMESTAMP && offset < 4)
			return timestamp[offset*8 +: 8];
		if (page == PAGE_TIMESTAMP && offset == 4)
			return {7'd0, timestamp[32]};
		return 8'h00;
	endfunction

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			value_errors++;
			$display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic read_byte(input cpu_addr_t addr, output byte_t data);
		@(negedge clk_24);
		cpu_addr = addr;
		cpu_wr = 1'b0;
		repeat (2) @(negedge clk_24);
		data = cpu_din;
	endtask

	task automatic write_byte(input cpu_addr_t addr, input byte_t data);
		@(negedge clk_24);
		cpu_addr = addr;
		cpu_dout = data;
		cpu_wr = 1'b1;
		@(negedge clk_24);
		cpu_wr = 1'b0;
	endtask

	task automatic download_byte(input dn_addr_t addr, input byte_t data, input byte_t index);
		@(negedge clk_24);
		dn_addr = addr;
		dn_data = data;
		dn_index = index;
		dn_wr = 1'b1;
		@(negedge clk_24);
		dn_wr = 1'b0;
	endtask

	// Checks the status byte every cycle while waiting for vertical blank
	task automatic wait_vblank(input logic level);
		int waited;
		waited = 0;
		while (vga_vb !== level && waited < FRAME_CYCLES)
		begin
			@(negedge clk_24);
			check_value("status byte", cpu_din, status_rule(vga_hs, vga_vs, vga_hb, vga_vb));
			waited++;
		end
		if (vga_vb !== level)
		begin
			timeout_errors++;
			$display("Timeout: vertical blank did not reach %0b within one frame", level);
		end
	endtask

	// Every completed video pulse must span its whole window
	always @(negedge clk_24)
	begin
		logic [3:0] level;
		level = {vga_vb, vga_hb, vga_vs, vga_hs};
		for (int k = 0; k < 4; k++)
		begin
			if (level[k] === 1'b1)
				pulse_run[k]++;
			else if (pulse_run[k] != 0)
			begin
				pulse_count[k]++;
				assert (pulse_run[k] == pulse_clocks(k))
				else
				begin
					value_errors++;
					$display("** Error at time %0t: %s high for %0d clocks, expected %0d",
						$time, pulse_names[k], pulse_run[k], pulse_clocks(k));
				end
				pulse_run[k] = 0;
			end
		end
	end

	a_status_read: assert property (@(posedge clk_24) disable iff (reset)
		(cpu_addr[15:8] == PAGE_STATUS) |->
		(cpu_din == status_rule(vga_hs, vga_vs, vga_hb, vga_vb)))
	else
	begin
		value_errors++;
		$display("** Error at time %0t: status byte does not follow the video outputs", $time);
	end

	a_unmapped_zero: assert property (@(posedge clk_24) disable iff (reset)
		(cpu_addr[15:12] == 4'h9 || cpu_addr[15:12] == 4'hA || cpu_addr[15:12] == 4'hB)
		|-> (cpu_din == 8'h00))
	else
	begin
		value_errors++;
		$display("** Error at time %0t: unmapped address %h reads nonzero", $time, cpu_addr);
	end

	a_pause_forces_wait: assert property (@(posedge clk_24) disable iff (reset)
		pause |-> cpu_wait)
	else
	begin
		value_errors++;
		$display("** Error at time %0t: cpu_wait low while pause is high", $time);
	end

	a_pause_releases: assert property (@(posedge clk_24) disable iff (reset)
		pause |=> (pause || !cpu_wait))
	else
	begin
		value_errors++;
		$display("** Error at time %0t: cpu_wait still high after pause", $time);
	end

	a_pause_write_waits: assert property (@(posedge clk_24) disable iff (reset)
		(cpu_addr[15:4] == PAUSE_NIBBLES && cpu_wr) |=> cpu_wait)
	else
	begin
		value_errors++;
		$display("** Error at time %0t: cpu_wait low after a pause write", $time);
	end

	initial
	begin
		cpu_addr_t rom_addr [32];
		byte_t rom_data [32];
		cpu_addr_t ram_addr [16];
		byte_t ram_data [16];
		cpu_addr_t base;
		byte_t data;
		int elapsed;

		reset = 1'b1;
		pause = 1'b0;
		cpu_addr = 16'h9000;
		cpu_dout = 8'h00;
		cpu_wr = 1'b0;
		dn_addr = '0;
		dn_wr = 1'b0;
		dn_data = 8'h00;
		dn_index = 8'h00;
		joystick = '0;
		paddle = '0;
		timestamp = '0;
		repeat (10) @(negedge clk_24);
		reset = 1'b0;

		// Idle state and unmapped reads
		check_value("cpu_wait after reset", cpu_wait, 1'b0);
		read_byte(16'h9000, data);
		check_value("read of 9000", data, 8'h00);
		read_byte(16'hA000, data);
		check_value("read of A000", data, 8'h00);

		// ROM download, then a second index that must not land
		base = cpu_addr_t'(next_random() & 32'h7FE0);
		for (int i = 0; i < 32; i++)
		begin
			rom_addr[i] = base + cpu_addr_t'(i);
			rom_data[i] = random_byte();
			download_byte({2'b00, rom_addr[i][14:0]}, rom_data[i], 8'd0);
		end
		for (int i = 0; i < 32; i++)
			download_byte({2'b00, rom_addr[i][14:0]}, ~rom_data[i], 8'd1);
		for (int i = 0; i < 32; i++)
		begin
			read_byte(rom_addr[i], data);
			check_value($sformatf("ROM read at %h", rom_addr[i]), data, rom_data[i]);
		end

		// RAM spread over the whole range, top address last
		for (int i = 0; i < 16; i++)
		begin
			ram_addr[i] = (i == 15) ? 16'hFFFF :
				cpu_addr_t'(16'hC000 | (i << 10) | (next_random() & 32'h3FF));
			ram_data[i] = random_byte();
			write_byte(ram_addr[i], ram_data[i]);
		end
		for (int i = 0; i < 16; i++)
		begin
			read_byte(ram_addr[i], data);
			check_value($sformatf("RAM read at %h", ram_addr[i]), data, ram_data[i]);
		end

		// Input pages
		@(negedge clk_24);
		for (int i = 0; i < 6; i++)
			joystick[i*32 +: 32] = next_random();
		for (int i = 0; i < 6; i++)
			paddle[i*8 +: 8] = random_byte();
		timestamp = {1'b1, next_random()};
		for (int o = 0; o < 32; o++)
		begin
			read_byte({PAGE_JOYSTICK, 8'(o)}, data);
			check_value($sformatf("joystick byte %0d", o), data,
				expected_input(PAGE_JOYSTICK, o));
		end
		for (int o = 0; o < 8; o++)
		begin
			read_byte({PAGE_PADDLE, 8'(o)}, data);
			check_value($sformatf("paddle byte %0d", o), data, expected_input(PAGE_PADDLE, o));
			read_byte({PAGE_TIMESTAMP, 8'(o)}, data);
			check_value($sformatf("timestamp byte %0d", o), data,
				expected_input(PAGE_TIMESTAMP, o));
		end

		// Let the timer leave zero so that the clear has something to undo
		@(negedge clk_24);
		cpu_addr = {PAGE_TIMER, 8'h00};
		@(negedge clk_24);
		elapsed = 0;
		while (cpu_din === 8'h00 && elapsed < TIMER_LIMIT)
		begin
			@(negedge clk_24);
			elapsed++;
		end
		if (cpu_din === 8'h00)
		begin
			timeout_errors++;
			$display("Timeout: the timer did not count up after reset");
		end

		// Timer clear and first millisecond
		write_byte(16'h8900, random_byte());
		check_value("timer after clear", cpu_din, 8'h00);
		elapsed = 0;
		while (cpu_din !== 8'h01 && elapsed < TIMER_LIMIT)
		begin
			@(negedge clk_24);
			elapsed++;
		end
		if (cpu_din !== 8'h01)
		begin
			timeout_errors++;
			$display("Timeout: the timer never reached one millisecond");
		end
		else
		begin
			assert (elapsed >= CLK_TICKS_PER_MS && elapsed < TIMER_LIMIT)
			else
			begin
				value_errors++;
				$display("** Error at time %0t: timer stepped after %0d clocks", $time, elapsed);
			end
		end
		read_byte(16'h8901, data);
		check_value("timer high byte", data, 8'h00);

		// Pause latch set by a write, released by the pause input
		write_byte(16'h8A30, random_byte());
		elapsed = 0;
		while (!cpu_wait && elapsed < 2)
		begin
			@(negedge clk_24);
			elapsed++;
		end
		if (!cpu_wait)
		begin
			timeout_errors++;
			$display("Timeout: cpu_wait did not rise after the pause write");
		end
		repeat (20)
		begin
			@(negedge clk_24);
			check_value("cpu_wait while latched", cpu_wait, 1'b1);
		end
		@(negedge clk_24);
		pause = 1'b1;
		@(negedge clk_24);
		pause = 1'b0;
		elapsed = 0;
		while (cpu_wait && elapsed < 4)
		begin
			@(negedge clk_24);
			elapsed++;
		end
		if (cpu_wait)
		begin
			timeout_errors++;
			$display("Timeout: cpu_wait did not fall after the pause pulse");
		end

		// Status page across a frame
		@(negedge clk_24);
		cpu_addr = {PAGE_STATUS, 8'h00};
		wait_vblank(1'b1);
		wait_vblank(1'b0);
		@(negedge clk_24);

		// Each video output has to have finished at least one pulse by now
		for (int k = 0; k < 4; k++)
		begin
			assert (pulse_count[k] > 0)
			else
			begin
				value_errors++;
				$display("%s never completed a pulse", pulse_names[k]);
			end
		end

		$display("Checks done with %0d value errors and %0d timeouts",
			value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
